// File: source/math_config.svh
// operand width, per-adder latency and adder tree latency macros
`ifndef MATH_CONFIG_SVH
`define MATH_CONFIG_SVH

// operand and result width in bits
// must be a multiple of MATH_LATENCY + 1
`define MATH_WIDTH 16

// register stages inside one fabric adder
// 1 gives two slices of half the width
`define MATH_LATENCY 1

// enabled cycles from operands to final sum
// two adder levels in the tree
`define MATH_TREE_LATENCY (2 * `MATH_LATENCY)

// defaults give
//   16-bit operands
//   two 8-bit slices per adder
//   two cycles through the tree

`endif

// File: source/math_pkg.sv
// operand, sum and four-operand bundle types for the summation unit
`include "math_config.svh"

package math_pkg;

  ////////////////////////////////////////////////////////////
  // scalar types
  ////////////////////////////////////////////////////////////

  // one operand or partial sum
  // signed two's complement
  typedef logic signed [`MATH_WIDTH-1:0] operand_t;

  // final sum of the tree
  // wraps modulo 2**MATH_WIDTH, no saturation
  typedef logic signed [`MATH_WIDTH-1:0] sum_t;

  ////////////////////////////////////////////////////////////
  // operand bundle
  ////////////////////////////////////////////////////////////

  // four operands accepted together
  // op0 sits in the top bits of the packed vector
  typedef struct packed {
    // low pair, into add_lo
    operand_t op0;
    operand_t op1;
    // high pair, into add_hi
    operand_t op2;
    operand_t op3;
  } operand_quad_t;

  // 4 x MATH_WIDTH bits overall
  // travels as one port into the top level

endpackage

// File: source/shift_reg.sv
// enabled delay line with synchronous reset, configurable width and depth
module shift_reg #(
  // bits per stage
  parameter int WIDTH = 1,
  // number of register stages, at least 1
  parameter int DEPTH = 1
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             ena,
  input  logic [WIDTH-1:0] din,
  output logic [WIDTH-1:0] dout
);

  // one word per stage
  typedef logic [WIDTH-1:0] word_t;

  // stage 0 takes din, stage DEPTH-1 drives dout
  word_t stages [DEPTH];

  // a zero-depth line has no register to hold data
  if (DEPTH < 1) begin : g_bad_depth
    $error("shift_reg: DEPTH must be at least 1");
  end

  ////////////////////////////////////////////////////////////
  // register chain
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      // whole line empties on reset
      for (int i = 0; i < DEPTH; i++) begin
        stages[i] <= '0;
      end
    end else if (ena) begin
      // every stage moves together
      stages[0] <= din;
      for (int i = 1; i < DEPTH; i++) begin
        stages[i] <= stages[i-1];
      end
    end
    // ena low holds every stage
  end

  ////////////////////////////////////////////////////////////
  // output
  ////////////////////////////////////////////////////////////

  // straight from the last register
  assign dout = stages[DEPTH-1];

endmodule

// File: source/math_add_fab.sv
// signed sliced fabric adder with registered inter-slice carries and skew lines
`include "math_config.svh"

module math_add_fab #(
  // adder width, multiple of LATENCY + 1
  parameter int WIDTH   = `MATH_WIDTH,
  // register stages from operands to dout
  parameter int LATENCY = `MATH_LATENCY
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               ena,
  input  math_pkg::operand_t dina,
  input  math_pkg::operand_t dinb,
  output math_pkg::operand_t dout
);

  // one slice per stage plus one
  localparam int NUM_SLICES = LATENCY + 1;
  localparam int SLICE_W    = WIDTH / NUM_SLICES;
  // index of the top slice
  localparam int NS         = NUM_SLICES - 1;

  // one narrow adder word
  typedef logic [SLICE_W-1:0] slice_t;

  // aligned operand slices at each narrow adder
  slice_t a [NUM_SLICES];
  slice_t b [NUM_SLICES];
  // narrow adder results before deskew
  slice_t slice_sum [NUM_SLICES];
  // deskewed slices, lowest slice in the low bits
  logic [NUM_SLICES-1:0][SLICE_W-1:0] out_bus;

  // carry out of every slice below the top one
  logic [NS-1:0] carry;
  // same carries one stage later
  logic [NS-1:0] carry_q;

  ////////////////////////////////////////////////////////////
  // elaboration checks
  ////////////////////////////////////////////////////////////

  if (LATENCY < 1) begin : g_bad_latency
    $error("math_add_fab: LATENCY must be at least 1");
  end

  if (WIDTH % NUM_SLICES != 0) begin : g_bad_width
    $error("math_add_fab: WIDTH must be a multiple of LATENCY + 1");
  end

  if (WIDTH != $bits(math_pkg::operand_t)) begin : g_bad_port
    $error("math_add_fab: WIDTH must match the operand type");
  end

  ////////////////////////////////////////////////////////////
  // carry registers
  ////////////////////////////////////////////////////////////

  // slice n carry is used by slice n+1 one stage later
  always_ff @(posedge clk) begin
    if (rst) begin
      carry_q <= '0;
    end else if (ena) begin
      carry_q <= carry;
    end
  end

  ////////////////////////////////////////////////////////////
  // slices
  ////////////////////////////////////////////////////////////

  for (genvar n = 0; n < NUM_SLICES; n++) begin : g_slice
    localparam int LO = n * SLICE_W;
    localparam int HI = LO + SLICE_W - 1;

    // input skew, slice n waits n stages for the carry chain
    if (n == 0) begin : g_no_skew
      assign a[n] = dina[HI:LO];
      assign b[n] = dinb[HI:LO];
    end else begin : g_skew
      logic [2*SLICE_W-1:0] skew_out;

      shift_reg #(
        .WIDTH (2 * SLICE_W),
        .DEPTH (n)
      ) skew_i (
        .clk  (clk),
        .rst  (rst),
        .ena  (ena),
        .din  ({dina[HI:LO], dinb[HI:LO]}),
        .dout (skew_out)
      );

      // a in the upper half, b in the lower
      assign a[n] = skew_out[2*SLICE_W-1:SLICE_W];
      assign b[n] = skew_out[SLICE_W-1:0];
    end

    // narrow adder
    if (n == 0) begin : g_first
      // no carry in at the bottom
      assign {carry[n], slice_sum[n]} = {1'b0, a[n]} + {1'b0, b[n]};
    end else if (n == NS) begin : g_last
      // top carry out dropped, result wraps
      assign slice_sum[n] = a[n] + b[n] + slice_t'(carry_q[n-1]);
    end else begin : g_mid
      assign {carry[n], slice_sum[n]} = {1'b0, a[n]} + {1'b0, b[n]}
                                      + {{SLICE_W{1'b0}}, carry_q[n-1]};
    end

    // output deskew, slice n waits NS-n stages for the top slice
    if (n == NS) begin : g_no_deskew
      // top slice is combinational from its skew registers
      assign out_bus[n] = slice_sum[n];
    end else begin : g_deskew
      shift_reg #(
        .WIDTH (SLICE_W),
        .DEPTH (NS - n)
      ) deskew_i (
        .clk  (clk),
        .rst  (rst),
        .ena  (ena),
        .din  (slice_sum[n]),
        .dout (out_bus[n])
      );
    end
  end

  // slices back together
  assign dout = out_bus;

endmodule

// File: source/math_sum4.sv
// four-operand signed adder tree with the valid strobe delayed alongside
`include "math_config.svh"

module math_sum4 (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    ena,
  input  logic                    valid_in,
  input  math_pkg::operand_quad_t operands,
  output math_pkg::sum_t          sum,
  output logic                    valid_out
);

  import math_pkg::*;

  // partial sum of op0 and op1
  operand_t sum_lo;
  // partial sum of op2 and op3
  operand_t sum_hi;

  ////////////////////////////////////////////////////////////
  // first level
  ////////////////////////////////////////////////////////////

  // low pair
  math_add_fab #(
    .WIDTH   (`MATH_WIDTH),
    .LATENCY (`MATH_LATENCY)
  ) add_lo (
    .clk  (clk),
    .rst  (rst),
    .ena  (ena),
    .dina (operands.op0),
    .dinb (operands.op1),
    .dout (sum_lo)
  );

  // high pair
  math_add_fab #(
    .WIDTH   (`MATH_WIDTH),
    .LATENCY (`MATH_LATENCY)
  ) add_hi (
    .clk  (clk),
    .rst  (rst),
    .ena  (ena),
    .dina (operands.op2),
    .dinb (operands.op3),
    .dout (sum_hi)
  );

  ////////////////////////////////////////////////////////////
  // second level
  ////////////////////////////////////////////////////////////

  // both partial sums arrive on the same cycle
  // dout is combinational from add_top's last stage
  math_add_fab #(
    .WIDTH   (`MATH_WIDTH),
    .LATENCY (`MATH_LATENCY)
  ) add_top (
    .clk  (clk),
    .rst  (rst),
    .ena  (ena),
    .dina (sum_lo),
    .dinb (sum_hi),
    .dout (sum)
  );

  ////////////////////////////////////////////////////////////
  // valid path
  ////////////////////////////////////////////////////////////

  // one bit per tree stage
  // same ena as the adders, so stalls keep it aligned
  // reset empties it, valid_out low from the first reset edge
  shift_reg #(
    .WIDTH (1),
    .DEPTH (`MATH_TREE_LATENCY)
  ) valid_dly (
    .clk  (clk),
    .rst  (rst),
    .ena  (ena),
    .din  (valid_in),
    .dout (valid_out)
  );

  // latency at the defaults
  //   add_lo / add_hi  1 cycle
  //   add_top          1 cycle
  //   total            2 enabled cycles

endmodule

// File: verif/math_sum4_asserts.sv
// concurrent checks on reset, stall hold and known output values of math_sum4
module math_sum4_asserts (
  input logic           clk,
  input logic           rst,
  input logic           ena,
  input logic           valid_out,
  input math_pkg::sum_t sum
);

  ////////////////////////////////////////////////////////////
  // reset
  ////////////////////////////////////////////////////////////

  // a reset edge empties the valid line
  a_reset_clears_valid : assert property (@(posedge clk) rst |=> !valid_out)
    else $error("valid_out high in the cycle after a reset edge");

  ////////////////////////////////////////////////////////////
  // stall
  ////////////////////////////////////////////////////////////

  // ena low freezes every register in the tree
  // so both outputs keep the value they had before the edge
  a_stall_holds_outputs : assert property (
    @(posedge clk) (!ena && !rst) |=> ($stable(sum) && $stable(valid_out))
  ) else $error("sum or valid_out changed across an edge with ena low");

  ////////////////////////////////////////////////////////////
  // output values
  ////////////////////////////////////////////////////////////

  // a flagged result must be fully driven
  a_sum_known : assert property (@(posedge clk) valid_out |-> !$isunknown(sum))
    else $error("sum has unknown bits while valid_out is high");

endmodule

// attach to every math_sum4 instance
bind math_sum4 math_sum4_asserts math_sum4_asserts_i (
  .clk       (clk),
  .rst       (rst),
  .ena       (ena),
  .valid_out (valid_out),
  .sum       (sum)
);

// File: verif/tb_math_sum4.sv
// testbench top for math_sum4 with clock, reset, stim file driver, result queue and checks
`include "math_config.svh"

module tb_math_sum4;

  import math_pkg::*;

  // stim file and its number of data lines
  localparam string STIM_FILE    = "verif/math_sum4_stim.txt";
  localparam int    STIM_LINES   = 48;
  localparam int    RESET_CYCLES = 16;
  // slack on top of the expected run length
  localparam int    MARGIN       = 20;
  localparam int    TIMEOUT_CYCLES =
    RESET_CYCLES + STIM_LINES + `MATH_TREE_LATENCY + MARGIN;

  logic          clk = 1'b0;
  logic          rst;
  logic          ena;
  logic          valid_in;
  operand_quad_t operands;
  sum_t          sum;
  logic          valid_out;

  // expected sums in issue order
  sum_t expected_q[$];
  int   cycle_count  = 0;
  int   lines_read   = 0;
  // ena and rst as the last rising edge saw them
  logic ena_at_edge  = 1'b0;
  logic rst_at_edge  = 1'b1;

  math_sum4 math_sum4_i (
    .clk       (clk),
    .rst       (rst),
    .ena       (ena),
    .valid_in  (valid_in),
    .operands  (operands),
    .sum       (sum),
    .valid_out (valid_out)
  );

  ////////////////////////////////////////////////////////////
  // clock and timeout
  ////////////////////////////////////////////////////////////

  initial begin
    forever #50 clk = ~clk;
  end

  // prints the reason, then ends the run as a failure
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped on a failed check");
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      report_failure($sformatf("simulation timed out after %0d cycles", cycle_count));
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  // one data line per clock
  // comment lines start with //
  task automatic drive_stim_file();
    int          fd;
    int          n;
    string       line;
    logic [31:0] line_ena;
    logic [31:0] line_valid;
    operand_t    op0;
    operand_t    op1;
    operand_t    op2;
    operand_t    op3;
    sum_t        line_sum;
    fd = $fopen(STIM_FILE, "r");
    assert (fd != 0) else report_failure("could not open the stim file");
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // blank and comment lines carry no cycle
      if (line.len() < 2 || line.substr(0, 1) == "//") begin
        continue;
      end
      n = $sscanf(line, "%h %h %h %h %h %h %h",
                  line_ena, line_valid, op0, op1, op2, op3, line_sum);
      assert (n == 7)
        else report_failure($sformatf("stim line %0d is malformed", lines_read + 1));
      lines_read++;
      @(posedge clk);
      ena          <= line_ena[0];
      valid_in     <= line_valid[0];
      operands.op0 <= op0;
      operands.op1 <= op1;
      operands.op2 <= op2;
      operands.op3 <= op3;
      // only an enabled, valid line enters the tree
      if (line_ena[0] && line_valid[0]) begin
        expected_q.push_back(line_sum);
      end
    end
    $fclose(fd);
  endtask

  initial begin
    // enabled valid stream during reset
    // reset alone must keep valid_out low
    rst      = 1'b1;
    ena      = 1'b1;
    valid_in = 1'b1;
    operands = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst      <= 1'b0;
    ena      <= 1'b0;
    valid_in <= 1'b0;
    drive_stim_file();
    assert (lines_read == STIM_LINES)
      else report_failure($sformatf("stim file has %0d data lines, %0d expected",
                                    lines_read, STIM_LINES));
    // drain with bubbles
    @(posedge clk);
    ena      <= 1'b1;
    valid_in <= 1'b0;
    repeat (`MATH_TREE_LATENCY + 1) @(posedge clk);
    assert (expected_q.size() == 0)
      else report_failure($sformatf("%0d expected results never came out",
                                    expected_q.size()));
    $display("STATUS: PASS");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // checking
  ////////////////////////////////////////////////////////////

  // outputs are settled at the falling edge
  always @(negedge clk) begin : check_outputs
    sum_t exp_sum;
    if (rst_at_edge) begin
      assert (valid_out == 1'b0) else report_failure("valid_out went high during reset");
    end else if (ena_at_edge && valid_out) begin
      assert (expected_q.size() > 0)
        else report_failure("valid_out high with no result pending");
      exp_sum = expected_q.pop_front();
      assert (sum == exp_sum)
        else report_failure($sformatf("Fail at time %0t: sum %h, expected %h",
                                      $time, sum, exp_sum));
    end
    // values the next rising edge will sample
    ena_at_edge = ena;
    rst_at_edge = rst;
  end

endmodule

// File: flist.f
+incdir+source
source/math_pkg.sv
source/shift_reg.sv
source/math_add_fab.sv
source/math_sum4.sv
verif/math_sum4_asserts.sv
verif/tb_math_sum4.sv

// File: run.sh
#!/bin/sh
# build and run the math_sum4 testbench with Verilator
# exit status is the simulator's, nonzero on any $fatal

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
  --top-module tb_math_sum4 \
  -Mdir obj_dir \
  -f flist.f &&
./obj_dir/Vtb_math_sum4 ||
{ echo "math_sum4 simulation did not complete cleanly"; exit 1; }

// File: verif/math_sum4_stim.txt
// columns: ena valid op0 op1 op2 op3 expected_sum, all in hex
// expected_sum only counts on lines where ena and valid are both 1
1 1 0001 0002 0003 0004 000A
1 1 0010 0020 0030 0040 00A0
1 1 0005 0005 0005 0005 0014
1 1 0000 0000 0000 0000 0000
1 1 0100 0200 0300 0400 0A00
1 1 0007 0011 0023 0001 003C
1 1 1234 0001 0002 0003 123A
1 1 0ABC 0DEF 0001 0002 18AE
1 1 00FF 0001 0000 0000 0100
1 1 00FF 00FF 00FF 00FF 03FC
1 1 0080 0080 0000 0000 0100
1 1 0000 0000 00FF 0001 0100
1 1 00FF 0000 0000 0001 0100
1 1 0FFF 0001 0000 0000 1000
1 1 00F0 0010 00F0 0010 0200
1 1 01FF 0001 02FF 0001 0500
1 1 FFFF 0001 0000 0000 0000
1 1 FFFF FFFF FFFF FFFF FFFC
1 1 8000 8000 0000 0000 0000
1 1 7FFF 0001 0000 0000 8000
1 1 7FFF 7FFF 7FFF 7FFF FFFC
1 1 8000 FFFF 0000 0000 7FFF
1 1 FF00 0100 0000 0000 0000
1 1 FFF6 000A 0005 FFFB 0000
1 1 8000 8000 8000 8000 0000
1 1 6000 6000 6000 0001 2001
1 1 0011 0022 0033 0044 00AA
1 1 0101 0101 0101 0101 0404
0 0 FFFF FFFF FFFF FFFF 0000
0 0 1111 2222 3333 4444 0000
0 0 ABCD ABCD ABCD ABCD 0000
1 1 0002 0004 0006 0008 0014
0 0 0F0F 0F0F 0F0F 0F0F 0000
1 1 FFFE FFFE 0001 0001 FFFE
1 1 00FF 00FF 0000 0002 0200
0 0 5555 5555 5555 5555 0000
0 0 5555 5555 5555 5555 0000
1 1 4000 4000 0000 0001 8001
1 0 1111 1111 1111 1111 0000
1 1 0003 0003 0003 0003 000C
1 0 2222 2222 2222 2222 0000
1 0 3333 3333 3333 3333 0000
1 1 FFFF 0000 0000 0000 FFFF
0 0 0000 0000 0000 0000 0000
1 0 7777 7777 7777 7777 0000
1 1 1000 2000 3000 4000 A000
1 1 C000 C000 C000 0123 4123
1 1 0FED 0001 F000 0001 FFEF
